// ==== rtl/rv_pkg.sv ====
package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_IF,
    ST_ID,
    ST_EX,
    ST_MEM,
    ST_WB
  } state_e;

  // ALU functions first, then branch compares
  typedef enum logic [4:0] {
    ALU_NONE,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_JALR,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU
  } alu_fun_e;

  typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_e;

  typedef enum logic [2:0] {OP2_RS2, OP2_IMI, OP2_IMS, OP2_IMJ, OP2_IMU} op2_sel_e;

  typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_MEM, WB_PC} wb_sel_e;

  // ********************
  // Opcode masks
  localparam word_t TYPE_ISB = 32'h0000_707f;
  localparam word_t TYPE_R   = 32'hfe00_707f;
  localparam word_t TYPE_UJ  = 32'h0000_007f;

  // ********************
  // Patterns matched under TYPE_ISB
  localparam word_t LW_INST    = 32'h0000_2003;
  localparam word_t SW_INST    = 32'h0000_2023;
  localparam word_t ADDI_INST  = 32'h0000_0013;
  localparam word_t ANDI_INST  = 32'h0000_7013;
  localparam word_t ORI_INST   = 32'h0000_6013;
  localparam word_t XORI_INST  = 32'h0000_4013;
  localparam word_t SLTI_INST  = 32'h0000_2013;
  localparam word_t SLTIU_INST = 32'h0000_3013;
  localparam word_t BEQ_INST   = 32'h0000_0063;
  localparam word_t BNE_INST   = 32'h0000_1063;
  localparam word_t BLT_INST   = 32'h0000_4063;
  localparam word_t BGE_INST   = 32'h0000_5063;
  localparam word_t BLTU_INST  = 32'h0000_6063;
  localparam word_t BGEU_INST  = 32'h0000_7063;
  localparam word_t JALR_INST  = 32'h0000_0067;

  // Patterns matched under TYPE_R
  localparam word_t ADD_INST   = 32'h0000_0033;
  localparam word_t SUB_INST   = 32'h4000_0033;
  localparam word_t SLL_INST   = 32'h0000_1033;
  localparam word_t SLT_INST   = 32'h0000_2033;
  localparam word_t SLTU_INST  = 32'h0000_3033;
  localparam word_t XOR_INST   = 32'h0000_4033;
  localparam word_t SRL_INST   = 32'h0000_5033;
  localparam word_t SRA_INST   = 32'h4000_5033;
  localparam word_t OR_INST    = 32'h0000_6033;
  localparam word_t AND_INST   = 32'h0000_7033;
  localparam word_t SLLI_INST  = 32'h0000_1013;
  localparam word_t SRLI_INST  = 32'h0000_5013;
  localparam word_t SRAI_INST  = 32'h4000_5013;

  // Patterns matched under TYPE_UJ
  localparam word_t JAL_INST   = 32'h0000_006f;
  localparam word_t LUI_INST   = 32'h0000_0037;
  localparam word_t AUIPC_INST = 32'h0000_0017;

  localparam word_t UNIMP_INST = 32'hc000_1073;

endpackage

// ==== rtl/ctrl_if.sv ====
`timescale 1ns/1ps

interface ctrl_if import rv_pkg::*; ();

  alu_fun_e  alu_fun;
  word_t     op1_data;
  word_t     op2_data;
  word_t     br_offset;
  logic      jump;
  logic      mem_wen;
  logic      rf_wen;
  wb_sel_e   wb_sel;
  reg_addr_t rd_addr;
  word_t     rs2_data;

  modport src (
    output alu_fun, op1_data, op2_data, br_offset, jump,
    output mem_wen, rf_wen, wb_sel, rd_addr, rs2_data
  );

  modport sink (
    input alu_fun, op1_data, op2_data, br_offset, jump,
    input mem_wen, rf_wen, wb_sel, rd_addr, rs2_data
  );

endinterface

// ==== rtl/rv_sequencer.sv ====
`timescale 1ns/1ps

module rv_sequencer import rv_pkg::*; #(
  parameter word_t start_addr = '0
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  br_flg,
  input  logic  jump,
  input  word_t br_target,
  input  word_t alu_out,
  output word_t pc,
  output logic  id_en,
  output logic  ex_en,
  output logic  wb_en,
  output logic  mem_phase
);

  state_e state;
  word_t  pc_next;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: state <= ST_IF;
        ST_IF:   state <= ST_ID;
        ST_ID:   state <= ST_EX;
        ST_EX:   state <= ST_MEM;
        ST_MEM:  state <= ST_WB;
        default: state <= ST_IF;
      endcase
    end
  end

  assign id_en     = (state == ST_ID);
  assign ex_en     = (state == ST_EX);
  assign wb_en     = (state == ST_WB);
  assign mem_phase = (state == ST_MEM) || (state == ST_WB);

  // Branch wins over jump, then fall through
  always_comb begin
    if (br_flg) begin
      pc_next = br_target;
    end else if (jump) begin
      pc_next = alu_out;
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= start_addr;
    end else if (wb_en) begin
      pc <= pc_next;
    end
  end

  a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
    state inside {ST_IDLE, ST_IF, ST_ID, ST_EX, ST_MEM, ST_WB});

endmodule

// ==== rtl/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  word_t     inst,
  input  word_t     pc,
  input  logic      id_en,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  ctrl_if.src       ctrl
);

  word_t    imm_i;
  word_t    imm_s;
  word_t    imm_b;
  word_t    imm_j;
  word_t    imm_u;
  word_t    inst_isb;
  word_t    inst_r;
  word_t    inst_uj;
  alu_fun_e dec_fun;
  op1_sel_e op1_sel;
  op2_sel_e op2_sel;
  logic     dec_mem_wen;
  logic     dec_rf_wen;
  wb_sel_e  dec_wb_sel;
  logic     dec_jump;
  word_t    op1_mux;
  word_t    op2_mux;

  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};

  assign inst_isb = inst & TYPE_ISB;
  assign inst_r   = inst & TYPE_R;
  assign inst_uj  = inst & TYPE_UJ;

  // ********************
  // Function code by pattern match
  always_comb begin
    case (inst_isb)
      LW_INST, SW_INST, ADDI_INST: dec_fun = ALU_ADD;
      ANDI_INST:  dec_fun = ALU_AND;
      ORI_INST:   dec_fun = ALU_OR;
      XORI_INST:  dec_fun = ALU_XOR;
      SLTI_INST:  dec_fun = ALU_SLT;
      SLTIU_INST: dec_fun = ALU_SLTU;
      BEQ_INST:   dec_fun = BR_BEQ;
      BNE_INST:   dec_fun = BR_BNE;
      BLT_INST:   dec_fun = BR_BLT;
      BGE_INST:   dec_fun = BR_BGE;
      BLTU_INST:  dec_fun = BR_BLTU;
      BGEU_INST:  dec_fun = BR_BGEU;
      JALR_INST:  dec_fun = ALU_JALR;
      default: begin
        case (inst_r)
          ADD_INST:             dec_fun = ALU_ADD;
          SUB_INST:             dec_fun = ALU_SUB;
          AND_INST:             dec_fun = ALU_AND;
          OR_INST:              dec_fun = ALU_OR;
          XOR_INST:             dec_fun = ALU_XOR;
          SLL_INST, SLLI_INST:  dec_fun = ALU_SLL;
          SRL_INST, SRLI_INST:  dec_fun = ALU_SRL;
          SRA_INST, SRAI_INST:  dec_fun = ALU_SRA;
          SLT_INST:             dec_fun = ALU_SLT;
          SLTU_INST:            dec_fun = ALU_SLTU;
          default: begin
            case (inst_uj)
              JAL_INST, LUI_INST, AUIPC_INST: dec_fun = ALU_ADD;
              default:                        dec_fun = ALU_NONE;
            endcase
          end
        endcase
      end
    endcase
  end

  // ********************
  // Operand and writeback form by opcode
  always_comb begin
    op1_sel     = OP1_RS1;
    op2_sel     = OP2_RS2;
    dec_mem_wen = 1'b0;
    dec_rf_wen  = 1'b0;
    dec_wb_sel  = WB_NONE;
    dec_jump    = 1'b0;
    // Unknown encodings leave everything idle
    if (dec_fun != ALU_NONE) begin
      case (inst_uj)
        LW_INST & TYPE_UJ: begin
          op2_sel    = OP2_IMI;
          dec_rf_wen = 1'b1;
          dec_wb_sel = WB_MEM;
        end
        SW_INST & TYPE_UJ: begin
          op2_sel     = OP2_IMS;
          dec_mem_wen = 1'b1;
        end
        ADDI_INST: begin
          op2_sel    = OP2_IMI;
          dec_rf_wen = 1'b1;
          dec_wb_sel = WB_ALU;
        end
        ADD_INST: begin
          dec_rf_wen = 1'b1;
          dec_wb_sel = WB_ALU;
        end
        JALR_INST: begin
          op2_sel    = OP2_IMI;
          dec_rf_wen = 1'b1;
          dec_wb_sel = WB_PC;
          dec_jump   = 1'b1;
        end
        JAL_INST: begin
          op1_sel    = OP1_PC;
          op2_sel    = OP2_IMJ;
          dec_rf_wen = 1'b1;
          dec_wb_sel = WB_PC;
          dec_jump   = 1'b1;
        end
        LUI_INST: begin
          op1_sel    = OP1_ZERO;
          op2_sel    = OP2_IMU;
          dec_rf_wen = 1'b1;
          dec_wb_sel = WB_ALU;
        end
        AUIPC_INST: begin
          op1_sel    = OP1_PC;
          op2_sel    = OP2_IMU;
          dec_rf_wen = 1'b1;
          dec_wb_sel = WB_ALU;
        end
        default: begin
          // Branches compare rs1 with rs2
          op1_sel = OP1_RS1;
        end
      endcase
    end
  end

  always_comb begin
    case (op1_sel)
      OP1_PC:   op1_mux = pc;
      OP1_ZERO: op1_mux = '0;
      default:  op1_mux = rs1_data;
    endcase
    case (op2_sel)
      OP2_IMI: op2_mux = imm_i;
      OP2_IMS: op2_mux = imm_s;
      OP2_IMJ: op2_mux = imm_j;
      OP2_IMU: op2_mux = imm_u;
      default: op2_mux = rs2_data;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl.alu_fun <= ALU_NONE;
      ctrl.jump    <= 1'b0;
      ctrl.mem_wen <= 1'b0;
      ctrl.rf_wen  <= 1'b0;
      ctrl.wb_sel  <= WB_NONE;
      ctrl.rd_addr <= '0;
    end else if (id_en) begin
      ctrl.alu_fun <= dec_fun;
      ctrl.jump    <= dec_jump;
      ctrl.mem_wen <= dec_mem_wen;
      ctrl.rf_wen  <= dec_rf_wen;
      ctrl.wb_sel  <= dec_wb_sel;
      ctrl.rd_addr <= inst[11:7];
    end
  end

  always_ff @(posedge clk) begin
    if (id_en) begin
      ctrl.op1_data  <= op1_mux;
      ctrl.op2_data  <= op2_mux;
      ctrl.br_offset <= imm_b;
      ctrl.rs2_data  <= rs2_data;
    end
  end

  a_store_no_rf_write: assert property (@(posedge clk) disable iff (!rst_n)
    !(ctrl.mem_wen && ctrl.rf_wen));

endmodule

// ==== rtl/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  ex_en,
  input  word_t pc,
  ctrl_if.sink  ctrl,
  output word_t alu_out,
  output word_t br_target,
  output logic  br_flg
);

  word_t op1;
  word_t op2;
  word_t sum;
  word_t alu_res;
  logic  lt_s;
  logic  lt_u;
  logic  br_take;

  assign op1  = ctrl.op1_data;
  assign op2  = ctrl.op2_data;
  assign sum  = op1 + op2;
  assign lt_s = $signed(op1) < $signed(op2);
  assign lt_u = op1 < op2;

  always_comb begin
    case (ctrl.alu_fun)
      ALU_ADD:  alu_res = sum;
      ALU_SUB:  alu_res = op1 - op2;
      ALU_AND:  alu_res = op1 & op2;
      ALU_OR:   alu_res = op1 | op2;
      ALU_XOR:  alu_res = op1 ^ op2;
      ALU_SLL:  alu_res = op1 << op2[4:0];
      ALU_SRL:  alu_res = op1 >> op2[4:0];
      ALU_SRA:  alu_res = $signed(op1) >>> op2[4:0];
      ALU_SLT:  alu_res = {31'b0, lt_s};
      ALU_SLTU: alu_res = {31'b0, lt_u};
      // Target must be halfword aligned
      ALU_JALR: alu_res = {sum[31:1], 1'b0};
      default:  alu_res = '0;
    endcase
  end

  always_comb begin
    case (ctrl.alu_fun)
      BR_BEQ:  br_take = (op1 == op2);
      BR_BNE:  br_take = (op1 != op2);
      BR_BLT:  br_take = lt_s;
      BR_BGE:  br_take = !lt_s;
      BR_BLTU: br_take = lt_u;
      BR_BGEU: br_take = !lt_u;
      default: br_take = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      br_flg <= 1'b0;
    end else if (ex_en) begin
      br_flg <= br_take;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_en) begin
      alu_out   <= alu_res;
      br_target <= pc + ctrl.br_offset;
    end
  end

endmodule

// ==== rtl/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  input  reg_addr_t rd_addr,
  input  logic      we,
  input  word_t     wd,
  output word_t     rs1_data,
  output word_t     rs2_data,
  output word_t     gp
);

  word_t regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd_addr != '0)) begin
      regs[rd_addr] <= wd;
    end
  end

  // x0 reads as zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  assign gp = regs[3];

  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
    regs[0] == '0);

endmodule

// ==== rtl/rv_core.sv ====
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
  parameter word_t start_addr = '0
) (
  input  logic  clk,
  input  logic  rst_n,
  input  word_t inst,
  input  word_t rdata,
  output word_t addr_i,
  output word_t addr_d,
  output logic  wen,
  output word_t wdata,
  output logic  exit,
  output word_t gp
);

  word_t     pc;
  word_t     alu_out;
  word_t     br_target;
  logic      br_flg;
  logic      id_en;
  logic      ex_en;
  logic      wb_en;
  logic      mem_phase;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     wb_data;

  ctrl_if ctrl ();

  rv_sequencer #(
    .start_addr (start_addr)
  ) u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .br_flg    (br_flg),
    .jump      (ctrl.jump),
    .br_target (br_target),
    .alu_out   (alu_out),
    .pc        (pc),
    .id_en     (id_en),
    .ex_en     (ex_en),
    .wb_en     (wb_en),
    .mem_phase (mem_phase)
  );

  rv_decoder u_dec (
    .clk      (clk),
    .rst_n    (rst_n),
    .inst     (inst),
    .pc       (pc),
    .id_en    (id_en),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .ctrl     (ctrl.src)
  );

  rv_execute u_exe (
    .clk       (clk),
    .rst_n     (rst_n),
    .ex_en     (ex_en),
    .pc        (pc),
    .ctrl      (ctrl.sink),
    .alu_out   (alu_out),
    .br_target (br_target),
    .br_flg    (br_flg)
  );

  // ********************
  // Writeback select
  always_comb begin
    case (ctrl.wb_sel)
      WB_MEM:  wb_data = rdata;
      WB_PC:   wb_data = pc + 32'd4;
      WB_ALU:  wb_data = alu_out;
      default: wb_data = alu_out;
    endcase
  end

  rv_regfile u_rf (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (ctrl.rd_addr),
    .we       (wb_en && ctrl.rf_wen),
    .wd       (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .gp       (gp)
  );

  // Memory ports
  assign addr_i = pc;
  assign addr_d = alu_out;
  assign wen    = mem_phase && ctrl.mem_wen;
  assign wdata  = ctrl.rs2_data;

  assign exit = (inst == UNIMP_INST);

endmodule

// ==== dv/core_checker.sv ====
`timescale 1ns/1ps

module core_checker import rv_pkg::*; #(
  parameter int max_exp = 64
) (
  input  logic  clk,
  input  logic  rst_n,
  input  word_t addr_i,
  input  logic  wen,
  input  word_t addr_d,
  input  word_t wdata,
  input  logic  exit,
  input  word_t gp,
  input  word_t exp_addr [max_exp],
  input  word_t exp_data [max_exp],
  input  int    n_exp,
  input  word_t exp_gp,
  output logic  done,
  output int    fail_cnt
);

  int   idx;
  int   pass_cnt;
  logic wen_q;
  logic fetch_bad;

  // ********************
  // One store against the next expected entry
  task automatic compare_store();
    logic ok;
    ok = 1'b1;
    if (idx >= n_exp) begin
      $display("Store %0d: unexpected write of %h to %h", idx, wdata, addr_d);
      fail_cnt++;
    end else begin
      if (addr_d !== exp_addr[idx]) begin
        $display("Mismatch addr_d: got %h, expected %h", addr_d, exp_addr[idx]);
        ok = 1'b0;
      end
      if (wdata !== exp_data[idx]) begin
        $display("Mismatch wdata: got %h, expected %h", wdata, exp_data[idx]);
        ok = 1'b0;
      end
      if (ok) begin
        $display("Store %0d: pass, %h at %h", idx, wdata, addr_d);
        pass_cnt++;
      end else begin
        $display("Store %0d: fail", idx);
        fail_cnt++;
      end
    end
    idx++;
  endtask

  // ********************
  // Program reached UNIMP
  task automatic report_completion();
    if (gp !== exp_gp) begin
      $display("Mismatch gp: got %h, expected %h", gp, exp_gp);
      fail_cnt++;
    end else begin
      $display("Final gp: pass, %h", gp);
      pass_cnt++;
    end
    if (idx < n_exp) begin
      $display("Stores: %0d of %0d expected stores never happened", n_exp - idx, n_exp);
      fail_cnt++;
    end else begin
      $display("Stores: pass, all %0d seen", n_exp);
      pass_cnt++;
    end
    $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    done = 1'b1;
  endtask

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx       = 0;
      pass_cnt  = 0;
      fail_cnt  = 0;
      wen_q     = 1'b0;
      fetch_bad = 1'b0;
      done      = 1'b0;
    end else if (!done) begin
      // Every fetch address is a whole word
      if (addr_i[1:0] != 2'b00 && !fetch_bad) begin
        $display("Fetch: pc %h is not word aligned", addr_i);
        fetch_bad = 1'b1;
        fail_cnt++;
      end
      // First edge of the write window is the one that ends MEM
      if (wen && !wen_q) begin
        compare_store();
      end
      wen_q = wen;
      if (exit === 1'b1) begin
        report_completion();
      end
    end
  end

endmodule

// ==== dv/tb_core.sv ====
`timescale 1ns/1ps

module tb_core import rv_pkg::*; ();

  localparam int    max_exp   = 64;
  localparam string stim_file = "dv/core_stim.txt";

  logic  clk;
  logic  rst_n;
  word_t inst;
  word_t rdata;
  word_t addr_i;
  word_t addr_d;
  logic  wen;
  word_t wdata;
  logic  exit;
  word_t gp;

  word_t mem [256];
  word_t exp_addr [max_exp];
  word_t exp_data [max_exp];
  int    n_exp;
  word_t exp_gp;
  int    n_inst;
  int    limit;
  int    cycles;
  logic  stim_ok;
  logic  done;
  int    fail_cnt;

  rv_core #(
    .start_addr (32'h0)
  ) UUT (
    .clk    (clk),
    .rst_n  (rst_n),
    .inst   (inst),
    .rdata  (rdata),
    .addr_i (addr_i),
    .addr_d (addr_d),
    .wen    (wen),
    .wdata  (wdata),
    .exit   (exit),
    .gp     (gp)
  );

  core_checker #(
    .max_exp (max_exp)
  ) chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .addr_i   (addr_i),
    .wen      (wen),
    .addr_d   (addr_d),
    .wdata    (wdata),
    .exit     (exit),
    .gp       (gp),
    .exp_addr (exp_addr),
    .exp_data (exp_data),
    .n_exp    (n_exp),
    .exp_gp   (exp_gp),
    .done     (done),
    .fail_cnt (fail_cnt)
  );

  always #50 clk = ~clk;

  // ********************
  // Memory model, word addressed, answers in the same cycle
  assign inst  = mem[addr_i[9:2]];
  assign rdata = mem[addr_d[9:2]];

  always @(posedge clk) begin
    if (wen) begin
      mem[addr_d[9:2]] <= wdata;
    end
  end

  task automatic load_stim();
    int    fd;
    int    cnt;
    string line;
    byte   tag;
    word_t a;
    word_t b;
    fd = $fopen(stim_file, "r");
    if (fd == 0) begin
      stim_ok = 1'b0;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      cnt  = $fgets(line, fd);
      if (cnt == 0 || line.len() < 3 || line[0] == "#") begin
        continue;
      end
      tag = line[0];
      a   = '0;
      b   = '0;
      cnt = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
      case (tag)
        "I": begin
          mem[a[9:2]] <= b;
          n_inst++;
        end
        "S": begin
          if (n_exp < max_exp) begin
            exp_addr[n_exp] = a;
            exp_data[n_exp] = b;
            n_exp++;
          end
        end
        "G": exp_gp = a;
        default: $display("Skipping unknown stimulus line: %s", line);
      endcase
    end
    $fclose(fd);
  endtask

  initial begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    n_exp   = 0;
    n_inst  = 0;
    cycles  = 0;
    exp_gp  = '0;
    stim_ok = 1'b1;
    for (int i = 0; i < 256; i++) begin
      mem[i] <= 32'hbad0_0000 | i;
    end
    load_stim();
    // Five cycles per instruction, with slack for a few passes
    limit = 5 * 4 * n_inst + 10;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    while (stim_ok && !done && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (stim_ok && done && fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      if (!stim_ok) begin
        $display("Could not open stimulus file %s", stim_file);
      end else if (!done) begin
        $display("Timeout: program did not reach exit within %0d cycles", limit);
      end
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== dv/core_stim.txt ====
# I <byte addr> <instruction word> | S <store addr> <store data> | G <final gp>
# All values in hex; text after the columns is ignored
I 00000000 ffb00093  addi x1, x0, -5
I 00000004 00300113  addi x2, x0, 3
I 00000008 00208233  add x4, x1, x2
I 0000000c 401102b3  sub x5, x2, x1
I 00000010 20402023  sw x4, 0x200(x0)
I 00000014 20502223  sw x5, 0x204(x0)
I 00000018 00209333  sll x6, x1, x2
I 0000001c 4010d393  srai x7, x1, 1
I 00000020 0020d433  srl x8, x1, x2
I 00000024 00734333  xor x6, x6, x7
I 00000028 00834333  xor x6, x6, x8
I 0000002c 20602423  sw x6, 0x208(x0)
I 00000030 0020a4b3  slt x9, x1, x2
I 00000034 0020b533  sltu x10, x1, x2
I 00000038 ffc0a593  slti x11, x1, -4
I 0000003c fff13613  sltiu x12, x2, -1
I 00000040 00259593  slli x11, x11, 2
I 00000044 00361613  slli x12, x12, 3
I 00000048 00151513  slli x10, x10, 1
I 0000004c 00a4e4b3  or x9, x9, x10
I 00000050 00b4e4b3  or x9, x9, x11
I 00000054 00c4e4b3  or x9, x9, x12
I 00000058 20902623  sw x9, 0x20c(x0)
I 0000005c 0f00f693  andi x13, x1, 0xf0
I 00000060 00a6e693  ori x13, x13, 0xa
I 00000064 fff6c693  xori x13, x13, -1
I 00000068 0016f6b3  and x13, x13, x1
I 0000006c 20d02823  sw x13, 0x210(x0)
I 00000070 12345737  lui x14, 0x12345
I 00000074 00001797  auipc x15, 0x1
I 00000078 00f70733  add x14, x14, x15
I 0000007c 20e02a23  sw x14, 0x214(x0)
I 00000080 20402803  lw x16, 0x204(x0)
I 00000084 10080813  addi x16, x16, 0x100
I 00000088 21002c23  sw x16, 0x218(x0)
I 0000008c 00208463  beq x1, x2, +8 (not taken)
I 00000090 00210463  beq x2, x2, +8 (taken)
I 00000094 3e002e23  sw x0, 0x3fc(x0) wrong path
I 00000098 00211463  bne x2, x2, +8 (not taken)
I 0000009c 00209463  bne x1, x2, +8 (taken)
I 000000a0 3e002e23  sw x0, 0x3fc(x0) wrong path
I 000000a4 00114463  blt x2, x1, +8 (not taken)
I 000000a8 0020c463  blt x1, x2, +8 (taken)
I 000000ac 3e002e23  sw x0, 0x3fc(x0) wrong path
I 000000b0 0020d463  bge x1, x2, +8 (not taken)
I 000000b4 00115463  bge x2, x1, +8 (taken)
I 000000b8 3e002e23  sw x0, 0x3fc(x0) wrong path
I 000000bc 0020e463  bltu x1, x2, +8 (not taken)
I 000000c0 00116463  bltu x2, x1, +8 (taken)
I 000000c4 3e002e23  sw x0, 0x3fc(x0) wrong path
I 000000c8 00117463  bgeu x2, x1, +8 (not taken)
I 000000cc 0020f463  bgeu x1, x2, +8 (taken)
I 000000d0 3e002e23  sw x0, 0x3fc(x0) wrong path
I 000000d4 008008ef  jal x17, +8
I 000000d8 3e002e23  sw x0, 0x3fc(x0) wrong path
I 000000dc 21102e23  sw x17, 0x21c(x0)
I 000000e0 0e100913  addi x18, x0, 0xe1
I 000000e4 010909e7  jalr x19, 16(x18)
I 000000e8 3e002e23  sw x0, 0x3fc(x0) wrong path
I 000000ec 3e002e23  sw x0, 0x3fc(x0) wrong path
I 000000f0 23302023  sw x19, 0x220(x0)
I 000000f4 011801b3  add x3, x16, x17
I 000000f8 c0001073  unimp
S 00000200 fffffffe
S 00000204 00000008
S 00000208 1fffffda
S 0000020c 0000000d
S 00000210 ffffff01
S 00000214 12346074
S 00000218 00000108
S 0000021c 000000d8
S 00000220 000000e8
G 000001e0

// ==== filelist.f ====
rtl/rv_pkg.sv
rtl/ctrl_if.sv
rtl/rv_sequencer.sv
rtl/rv_decoder.sv
rtl/rv_execute.sv
rtl/rv_regfile.sv
rtl/rv_core.sv
dv/core_checker.sv
dv/tb_core.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_core
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR) --top-module $(TOP)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
